// ==== design/csrDecode.sv ====
/* CSR request decoder
   splits a SYSTEM request into a legal CSR command or a trap command */
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csrDecode (
    input  csrPkg::sysReqT  req,
    output csrPkg::csrCmdT  csrCmd,
    output csrPkg::trapCmdT trapCmd
);

    csrPkg::csrOpE        op;
    logic                 opOk;
    logic                 immForm;
    logic [`CSR_XLEN-1:0] srcVal;
    logic                 wantWrite;
    logic                 addrOk;
    logic                 roViolation;
    logic                 csrLegal;
    logic                 isCsr;

    // funct3 to operation, 000 and 100 are unused
    always_comb begin
        op   = csrPkg::CSR_OP_WRITE;
        opOk = 1'b1;
        case (req.funct3)
            3'b001, 3'b101: op = csrPkg::CSR_OP_WRITE;
            3'b010, 3'b110: op = csrPkg::CSR_OP_SET;
            3'b011, 3'b111: op = csrPkg::CSR_OP_CLEAR;
            default:        opOk = 1'b0;
        endcase
    end

    // immediate forms carry zimm in the rs1 field
    assign immForm = req.funct3[2];
    assign srcVal  = immForm ? {{(`CSR_XLEN-5){1'b0}}, req.rs1Idx} : req.rs1Data;

    // set/clear with x0 or zimm 0 is a pure read
    assign wantWrite = (op == csrPkg::CSR_OP_WRITE) || (req.rs1Idx != 5'd0);

    // implemented address set
    always_comb begin
        case (req.csrAddr)
            `CSR_MSTATUS,
            `CSR_MTVEC,
            `CSR_MSCRATCH,
            `CSR_MEPC,
            `CSR_MCAUSE,
            `CSR_MHARTID: addrOk = 1'b1;
            default:      addrOk = 1'b0;
        endcase
    end

    // mhartid may be read but never written
    assign roViolation = (req.csrAddr == `CSR_MHARTID) && wantWrite;
    assign csrLegal    = opOk && addrOk && !roViolation;
    assign isCsr       = (req.kind == csrPkg::SYS_CSR);

    // legal CSR access
    always_comb begin
        csrCmd.valid   = req.valid && isCsr && csrLegal;
        csrCmd.op      = op;
        csrCmd.addr    = req.csrAddr;
        csrCmd.src     = srcVal;
        csrCmd.writeEn = wantWrite;
    end

    // everything else goes to the trap path
    always_comb begin
        trapCmd.valid  = req.valid && !(isCsr && csrLegal);
        trapCmd.isMret = (req.kind == csrPkg::SYS_MRET);
        trapCmd.epc    = req.pc;
        case (req.kind)
            csrPkg::SYS_ECALL:  trapCmd.cause = `CSR_XLEN'(`CAUSE_ECALL_M);
            csrPkg::SYS_EBREAK: trapCmd.cause = `CSR_XLEN'(`CAUSE_BREAK);
            // cause unused by MRET
            csrPkg::SYS_MRET:   trapCmd.cause = '0;
            default:            trapCmd.cause = `CSR_XLEN'(`CAUSE_ILLEGAL);
        endcase
    end

endmodule

`default_nettype wire

// ==== design/csrFile.sv ====
/* machine CSR storage
   reads the addressed CSR and applies read-modify-write and trap updates */
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csrFile (
    input  logic                   clk,
    input  logic                   arstN,
    input  csrPkg::csrCmdT         csrCmd,
    input  csrPkg::trapCmdT        trapCmd,
    output logic [`CSR_XLEN-1:0]   rdData,
    output csrPkg::csrStateT       csrState
);

    // mtvec, mepc and the mstatus bits live in the state struct
    csrPkg::csrStateT     state;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mcause;

    logic [`CSR_XLEN-1:0] mstatusRd;
    logic [`CSR_XLEN-1:0] wrVal;
    logic                 csrWr;

    // mstatus view, MPP pinned to machine mode
    always_comb begin
        mstatusRd                           = '0;
        mstatusRd[`CSR_MIE_BIT]             = state.mie;
        mstatusRd[`CSR_MPIE_BIT]            = state.mpie;
        mstatusRd[`CSR_MPP_HI:`CSR_MPP_LO]  = 2'b11;
    end

    // old value of the addressed CSR
    always_comb begin
        case (csrCmd.addr)
            `CSR_MSTATUS:  rdData = mstatusRd;
            `CSR_MTVEC:    rdData = state.mtvec;
            `CSR_MSCRATCH: rdData = mscratch;
            `CSR_MEPC:     rdData = state.mepc;
            `CSR_MCAUSE:   rdData = mcause;
            // mhartid and unknown addresses
            default:       rdData = '0;
        endcase
    end

    // new value from old value and source
    always_comb begin
        case (csrCmd.op)
            csrPkg::CSR_OP_SET:   wrVal = rdData | csrCmd.src;
            csrPkg::CSR_OP_CLEAR: wrVal = rdData & ~csrCmd.src;
            default:              wrVal = csrCmd.src;
        endcase
    end

    assign csrWr = csrCmd.valid && csrCmd.writeEn;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= '0;
            mscratch <= '0;
            mcause   <= '0;
        end else if (trapCmd.valid) begin
            // decode never raises both commands together
            if (trapCmd.isMret) begin
                // return from trap
                state.mie  <= state.mpie;
                state.mpie <= 1'b1;
            end else begin
                // trap entry, interrupts off
                state.mepc <= {trapCmd.epc[`CSR_XLEN-1:2], 2'b00};
                mcause     <= trapCmd.cause;
                state.mpie <= state.mie;
                state.mie  <= 1'b0;
            end
        end else if (csrWr) begin
            case (csrCmd.addr)
                `CSR_MSTATUS: begin
                    // only MIE and MPIE are kept
                    state.mie  <= wrVal[`CSR_MIE_BIT];
                    state.mpie <= wrVal[`CSR_MPIE_BIT];
                end
                `CSR_MTVEC: begin
                    // direct mode only, base is word aligned
                    state.mtvec <= {wrVal[`CSR_XLEN-1:2], 2'b00};
                end
                `CSR_MSCRATCH: begin
                    mscratch <= wrVal;
                end
                `CSR_MEPC: begin
                    state.mepc <= {wrVal[`CSR_XLEN-1:2], 2'b00};
                end
                `CSR_MCAUSE: begin
                    mcause <= wrVal;
                end
                default: begin
                    // mhartid writes are stopped in decode
                end
            endcase
        end
    end

    // trap path sees the live register values
    assign csrState = state;

endmodule

`default_nettype wire

// ==== design/csrPkg.sv ====
/* CSR and trap block types
   request, command, state and response structs shared by the RTL and testbench */
`default_nettype none

`include "csr_macros.svh"

package csrPkg;

    // kind of SYSTEM instruction handed over by execute
    typedef enum logic [1:0] {
        SYS_CSR,
        SYS_ECALL,
        SYS_EBREAK,
        SYS_MRET
    } sysKindE;

    // read-modify-write flavour of a CSR instruction
    typedef enum logic [1:0] {
        CSR_OP_WRITE,
        CSR_OP_SET,
        CSR_OP_CLEAR
    } csrOpE;

    // raw request from execute
    typedef struct packed {
        logic                 valid;
        sysKindE              kind;
        logic [`CSR_XLEN-1:0] pc;
        logic [2:0]           funct3;
        logic [11:0]          csrAddr;
        logic [4:0]           rs1Idx;
        logic [`CSR_XLEN-1:0] rs1Data;
    } sysReqT;

    // decoded, legal CSR access
    typedef struct packed {
        logic                 valid;
        csrOpE                op;
        logic [11:0]          addr;
        logic [`CSR_XLEN-1:0] src;
        logic                 writeEn;
    } csrCmdT;

    // trap entry or MRET
    typedef struct packed {
        logic                 valid;
        logic                 isMret;
        logic [`CSR_XLEN-1:0] cause;
        logic [`CSR_XLEN-1:0] epc;
    } trapCmdT;

    // CSR state the trap path needs
    typedef struct packed {
        logic [`CSR_XLEN-1:0] mtvec;
        logic [`CSR_XLEN-1:0] mepc;
        logic                 mie;
        logic                 mpie;
    } csrStateT;

    // registered reply to the pipeline
    typedef struct packed {
        logic                 valid;
        logic [`CSR_XLEN-1:0] rdData;
        logic                 redirect;
        logic [`CSR_XLEN-1:0] redirectPc;
    } sysRespT;

endpackage

`default_nettype wire

// ==== design/csrUnit.sv ====
/* machine CSR and trap unit
   decode, CSR file and trap sequencer, one cycle request to response */
`timescale 1ns/1ps
`default_nettype none

module csrUnit (
    input  logic            clk,
    input  logic            arstN,
    input  csrPkg::sysReqT  req,
    output csrPkg::sysRespT resp
);

    csrPkg::csrCmdT   csrCmd;
    csrPkg::trapCmdT  trapCmd;
    csrPkg::csrStateT csrState;
    logic [63:0]      rdData;

    // combinational split of the request
    csrDecode decode0 (
        .req     (req),
        .csrCmd  (csrCmd),
        .trapCmd (trapCmd)
    );

    // registers and old-value read
    csrFile file0 (
        .clk      (clk),
        .arstN    (arstN),
        .csrCmd   (csrCmd),
        .trapCmd  (trapCmd),
        .rdData   (rdData),
        .csrState (csrState)
    );

    // response register
    trapUnit trap0 (
        .clk      (clk),
        .arstN    (arstN),
        .trapCmd  (trapCmd),
        .csrValid (csrCmd.valid),
        .rdData   (rdData),
        .csrState (csrState),
        .resp     (resp)
    );

endmodule

`default_nettype wire

// ==== design/csr_macros.svh ====
/* CSR block constants
   data width, machine CSR addresses, mstatus bit positions and trap causes */
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// machine word width
`define CSR_XLEN 64

// implemented machine CSR addresses
`define CSR_MSTATUS  12'h300
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
// read-only, always reads as hart 0
`define CSR_MHARTID  12'hF14

// writable mstatus bits
`define CSR_MIE_BIT  3
`define CSR_MPIE_BIT 7
// MPP field, hardwired to machine mode
`define CSR_MPP_LO   11
`define CSR_MPP_HI   12

// mcause values
`define CAUSE_ILLEGAL 2
`define CAUSE_BREAK   3
`define CAUSE_ECALL_M 11

`endif

// ==== design/trapUnit.sv ====
/* trap sequencer and response register
   builds the one-cycle reply with old CSR data or a redirect target */
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module trapUnit (
    input  logic                   clk,
    input  logic                   arstN,
    input  csrPkg::trapCmdT        trapCmd,
    input  logic                   csrValid,
    input  logic [`CSR_XLEN-1:0]   rdData,
    input  csrPkg::csrStateT       csrState,
    output csrPkg::sysRespT        resp
);

    logic                 anyValid;
    logic [`CSR_XLEN-1:0] trapTarget;

    // control flops
    logic                 validQ;
    logic                 redirectQ;
    // payload flops
    logic [`CSR_XLEN-1:0] rdDataQ;
    logic [`CSR_XLEN-1:0] redirectPcQ;

    assign anyValid = csrValid || trapCmd.valid;

    // MRET returns to mepc, anything else enters at the mtvec base
    assign trapTarget = trapCmd.isMret ? csrState.mepc : csrState.mtvec;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ    <= 1'b0;
            redirectQ <= 1'b0;
        end else begin
            validQ    <= anyValid;
            redirectQ <= trapCmd.valid;
        end
    end

    // payload only moves with a request
    always_ff @(posedge clk) begin
        if (anyValid) begin
            if (trapCmd.valid) begin
                // traps and MRET write nothing back
                rdDataQ     <= '0;
                redirectPcQ <= trapTarget;
            end else begin
                // old CSR value, sampled before the file updates
                rdDataQ     <= rdData;
                redirectPcQ <= '0;
            end
        end
    end

    assign resp.valid      = validQ;
    assign resp.redirect   = redirectQ;
    assign resp.rdData     = rdDataQ;
    assign resp.redirectPc = redirectPcQ;

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
+incdir+tb
design/csrPkg.sv
design/csrDecode.sv
design/csrFile.sv
design/trapUnit.sv
design/csrUnit.sv
tb/csrUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module csrUnitTb -o csrUnitSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/csrUnitSim)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^SIMULATION PASSED$"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== tb/csrRefModel.svh ====
/* CSR reference model for the testbench
   shadow machine CSRs and the queue of expected responses */
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// shadow state, all zero out of reset
logic        mMie     = 1'b0;
logic        mMpie    = 1'b0;
logic [63:0] mMtvec   = '0;
logic [63:0] mMscratch = '0;
logic [63:0] mMepc    = '0;
logic [63:0] mMcause  = '0;

// one entry per clock edge, oldest first
csrPkg::sysRespT expQ[$];

// value of an implemented CSR, known drops for any other address
function automatic logic [63:0] shadowRead(input logic [11:0] addr, output logic known);
    logic [63:0] v;
    v = '0;
    known = 1'b1;
    case (addr)
        `CSR_MSTATUS: begin
            v[`CSR_MIE_BIT]  = mMie;
            v[`CSR_MPIE_BIT] = mMpie;
            // machine mode only
            v[12:11]         = 2'b11;
        end
        `CSR_MTVEC:    v = mMtvec;
        `CSR_MSCRATCH: v = mMscratch;
        `CSR_MEPC:     v = mMepc;
        `CSR_MCAUSE:   v = mMcause;
        `CSR_MHARTID:  v = '0;
        default:       known = 1'b0;
    endcase
    return v;
endfunction

// store with the per-register masks
task automatic shadowWrite(input logic [11:0] addr, input logic [63:0] val);
    case (addr)
        `CSR_MSTATUS: begin
            mMie  = val[`CSR_MIE_BIT];
            mMpie = val[`CSR_MPIE_BIT];
        end
        `CSR_MTVEC:    mMtvec    = {val[63:2], 2'b00};
        `CSR_MSCRATCH: mMscratch = val;
        `CSR_MEPC:     mMepc     = {val[63:2], 2'b00};
        `CSR_MCAUSE:   mMcause   = val;
        default: begin
        end
    endcase
endtask

// request taken on this edge, live is low while the DUT sits in reset
task automatic modelAccept(input csrPkg::sysReqT r, input logic live);
    csrPkg::sysRespT e;
    logic [63:0]     oldVal;
    logic [63:0]     src;
    logic [63:0]     newVal;
    logic            known;
    logic            doWrite;
    logic [63:0]     cause;
    e       = '0;
    cause   = 64'(`CAUSE_ILLEGAL);
    oldVal  = shadowRead(r.csrAddr, known);
    // CSRRW always writes, set and clear need a nonzero rs1 field
    doWrite = (r.funct3[1:0] == 2'b01) || (r.rs1Idx != 5'd0);
    src     = r.funct3[2] ? 64'(r.rs1Idx) : r.rs1Data;
    if (live && r.valid) begin
        e.valid = 1'b1;
        if (r.kind == csrPkg::SYS_CSR && known && r.funct3[1:0] != 2'b00
            && !(r.csrAddr == `CSR_MHARTID && doWrite)) begin
            e.rdData = oldVal;
            case (r.funct3[1:0])
                2'b01:   newVal = src;
                2'b10:   newVal = oldVal | src;
                default: newVal = oldVal & ~src;
            endcase
            if (doWrite) begin
                shadowWrite(r.csrAddr, newVal);
            end
        end else if (r.kind == csrPkg::SYS_MRET) begin
            e.redirect   = 1'b1;
            e.redirectPc = mMepc;
            mMie         = mMpie;
            mMpie        = 1'b1;
        end else begin
            // ecall, ebreak or any illegal CSR form
            if (r.kind == csrPkg::SYS_ECALL) begin
                cause = 64'(`CAUSE_ECALL_M);
            end else if (r.kind == csrPkg::SYS_EBREAK) begin
                cause = 64'(`CAUSE_BREAK);
            end
            e.redirect   = 1'b1;
            e.redirectPc = mMtvec;
            mMepc        = {r.pc[63:2], 2'b00};
            mMcause      = cause;
            mMpie        = mMie;
            mMie         = 1'b0;
        end
    end
    expQ.push_back(e);
endtask

`endif

// ==== tb/csrUnitTb.sv ====
/* testbench for the machine CSR and trap unit
   directed and seeded random SYSTEM requests checked against a shadow model */
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csrUnitTb;

    localparam int RESET_CYCLES = 5;
    localparam int NUM_RANDOM   = 3000;
    localparam int DRAIN_LIMIT  = 10;

    logic            clk;
    logic            arstN;
    csrPkg::sysReqT  req;
    csrPkg::sysRespT resp;

    csrPkg::sysReqT  lastReq;
    csrPkg::sysReqT  idleReq;
    csrPkg::sysRespT expResp;
    int              errors;
    logic            running;

    `include "csrRefModel.svh"

    csrUnit dut0 (
        .clk   (clk),
        .arstN (arstN),
        .req   (req),
        .resp  (resp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [63:0] expVal,
                              input logic [63:0] actVal);
        if (actVal !== expVal) begin
            errors++;
            $display("FAILED at %0t: %s expected 0x%h got 0x%h", $time, name, expVal, actVal);
        end
    endtask

    // six implemented addresses, then two unknown ones
    function automatic logic [11:0] pickAddr(input int sel);
        case (sel)
            0:       return `CSR_MSTATUS;
            1:       return `CSR_MTVEC;
            2:       return `CSR_MSCRATCH;
            3:       return `CSR_MEPC;
            4:       return `CSR_MCAUSE;
            5:       return `CSR_MHARTID;
            6:       return 12'h301;
            default: return 12'h7C0;
        endcase
    endfunction

    function automatic csrPkg::sysReqT makeCsrReq(input logic [2:0] f3, input logic [11:0] addr,
                                                  input logic [4:0] idx, input logic [63:0] data);
        csrPkg::sysReqT r;
        r         = '0;
        r.valid   = 1'b1;
        r.kind    = csrPkg::SYS_CSR;
        r.funct3  = f3;
        r.csrAddr = addr;
        r.rs1Idx  = idx;
        r.rs1Data = data;
        return r;
    endfunction

    function automatic csrPkg::sysReqT makeTrapReq(input csrPkg::sysKindE kind,
                                                   input logic [63:0] pc);
        csrPkg::sysReqT r;
        r       = '0;
        r.valid = 1'b1;
        r.kind  = kind;
        r.pc    = pc;
        return r;
    endfunction

    // mostly CSR forms, about a fifth idle
    function automatic csrPkg::sysReqT randomReq();
        csrPkg::sysReqT r;
        int             roll;
        roll = int'($urandom_range(0, 9));
        r = makeCsrReq(3'($urandom_range(0, 7)), pickAddr(int'($urandom_range(0, 7))),
                       5'($urandom()), {$urandom(), $urandom()});
        // keep most funct3 codes legal
        if (r.funct3[1:0] == 2'b00 && $urandom_range(0, 3) != 0) begin
            r.funct3[0] = 1'b1;
        end
        // zero rs1 turns set and clear into pure reads
        if ($urandom_range(0, 3) == 0) begin
            r.rs1Idx = 5'd0;
        end
        r.pc = {$urandom(), $urandom()};
        if (roll == 7) begin
            r.kind = csrPkg::SYS_ECALL;
        end else if (roll == 8) begin
            r.kind = csrPkg::SYS_EBREAK;
        end else if (roll == 9) begin
            r.kind = csrPkg::SYS_MRET;
        end
        r.valid = ($urandom_range(0, 9) < 8);
        return r;
    endfunction

    // request held over the last cycle is taken on this edge
    task automatic driveReq(input csrPkg::sysReqT r);
        @(posedge clk);
        modelAccept(lastReq, arstN);
        req     <= r;
        lastReq = r;
    endtask

    // response of the edge before, stable at the falling edge
    always @(negedge clk) begin
        if (running) begin
            if (expQ.size() == 0) begin
                errors++;
                $display("ERROR at %0t: a response came due with no expected entry", $time);
            end else begin
                expResp = expQ.pop_front();
                checkValue("resp.valid", 64'(expResp.valid), 64'(resp.valid));
                checkValue("resp.redirect", 64'(expResp.redirect), 64'(resp.redirect));
                if (expResp.valid) begin
                    checkValue("resp.rdData", expResp.rdData, resp.rdData);
                end
                if (expResp.redirect) begin
                    checkValue("resp.redirectPc", expResp.redirectPc, resp.redirectPc);
                end
            end
        end
    end

    initial begin
        int waited;
        void'($urandom(8813));
        idleReq  = '0;
        lastReq  = '0;
        req      = '0;
        arstN    = 1'b0;
        errors   = 0;
        running  = 1'b0;
        // checker starts once the first edge has queued an entry
        driveReq(idleReq);
        running = 1'b1;
        repeat (RESET_CYCLES - 1) driveReq(idleReq);
        arstN <= 1'b1;
        // every implemented CSR reads zero, mstatus shows MPP
        for (int i = 0; i < 6; i++) begin
            driveReq(makeCsrReq(3'b010, pickAddr(i), 5'd0, '0));
        end
        // trap entry and return with MIE on
        driveReq(makeCsrReq(3'b001, `CSR_MTVEC, 5'd1, 64'h8000_0103));
        driveReq(makeCsrReq(3'b110, `CSR_MSTATUS, 5'd8, '0));
        driveReq(makeTrapReq(csrPkg::SYS_ECALL, 64'h1000_0006));
        driveReq(makeCsrReq(3'b010, `CSR_MEPC, 5'd0, '0));
        driveReq(makeCsrReq(3'b010, `CSR_MCAUSE, 5'd0, '0));
        driveReq(makeCsrReq(3'b010, `CSR_MSTATUS, 5'd0, '0));
        driveReq(makeTrapReq(csrPkg::SYS_MRET, '0));
        // mhartid is read-only
        driveReq(makeCsrReq(3'b001, `CSR_MHARTID, 5'd3, 64'h5));
        driveReq(idleReq);
        repeat (NUM_RANDOM) driveReq(randomReq());
        driveReq(idleReq);
        waited = 0;
        while (expQ.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        running = 1'b0;
        if (expQ.size() != 0) begin
            errors++;
            $display("ERROR: %0d expected responses were never checked", expQ.size());
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // hard stop if the run never reaches its end
    initial begin
        #1_000_000;
        $display("ERROR: run timed out before the final report");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire
